//--- compile.f
common/axi_slave_pkg.sv
src/burst_addr_gen.sv
src/byte_mem.sv
write_ch/axi_write_ctrl.sv
read_ch/axi_read_ctrl.sv
src/axi_slave_top.sv
verif/tb_axi_slave.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run the testbench, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_axi_slave -f compile.f \
  -o sim_axi_slave > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_axi_slave > sim.log 2>&1
cat sim.log
grep -qx "Done: no errors" sim.log && echo "simulation passed" || {
  echo "simulation failed"
  exit 1
}

//--- verif/tb_axi_slave.sv
// testbench for the AXI-style slave with clock, reset, stimulus, byte model and checks
`timescale 1ns/10ps

module tb_axi_slave;

  typedef logic [axi_slave_pkg::MEM_AW-1:0] idx_t;

  logic                     clk;
  logic                     resetn;
  logic                     aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic                     ar_valid, ar_ready, r_valid, r_ready;
  axi_slave_pkg::addr_req_t aw, ar;
  axi_slave_pkg::w_beat_t   w;
  axi_slave_pkg::b_resp_t   b;
  axi_slave_pkg::r_beat_t   r;

  logic [7:0]  model_mem [axi_slave_pkg::MEM_BYTES];  // expected memory contents
  logic [15:0] lfsr_state = 16'd58;
  int          errors, errors_at_start, checks, tests_run;
  int          max_wait = 200;                         // cycles per handshake wait

  axi_slave_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  a_w_b_apart: assert property (@(posedge clk) disable iff (!resetn) !(w_ready && b_valid))
    else begin
      $display("write data and write response channels were open at the same time");
      errors++;
    end

  a_ar_closed: assert property (@(posedge clk) disable iff (!resetn) r_valid |-> !ar_ready)
    else begin
      $display("read address accepted while a read burst was still running");
      errors++;
    end

  ////////////////////////////////////////////////////////////
  // stimulus source and reference model
  ////////////////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic next_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], next_bit()};
    end
    return v;
  endfunction

  function automatic axi_slave_pkg::addr_req_t make_req(
    input logic [axi_slave_pkg::ID_W-1:0]  id,
    input logic [axi_slave_pkg::ADDR_W-1:0] addr,
    input logic [axi_slave_pkg::LEN_W-1:0] len,
    input logic [2:0]                      size,
    input axi_slave_pkg::burst_e           burst
  );
    axi_slave_pkg::addr_req_t req;
    req.id    = id;
    req.addr  = addr;
    req.len   = len;
    req.size  = size;
    req.burst = burst;
    return req;
  endfunction

  function automatic axi_slave_pkg::resp_e expected_resp(input axi_slave_pkg::addr_req_t req);
    if (req.addr >= axi_slave_pkg::MEM_BYTES) return axi_slave_pkg::RESP_DECERR;
    if (req.size > axi_slave_pkg::MAX_SIZE) return axi_slave_pkg::RESP_SLVERR;
    if (req.burst == axi_slave_pkg::BURST_WRAP &&
        !(req.len == 4'd1 || req.len == 4'd3 || req.len == 4'd7 || req.len == 4'd15)) begin
      return axi_slave_pkg::RESP_SLVERR;
    end
    return axi_slave_pkg::RESP_OKAY;
  endfunction

  // start address of beat k
  function automatic int model_addr(input axi_slave_pkg::addr_req_t req, input int k);
    int step;
    int win;
    int base;
    step = 1 << req.size;
    win  = (int'(req.len) + 1) * step;              // wrap window in bytes
    base = int'(req.addr) - (int'(req.addr) % win);
    case (req.burst)
      axi_slave_pkg::BURST_FIXED: return int'(req.addr);
      axi_slave_pkg::BURST_WRAP:  return base + ((int'(req.addr) - base + k * step) % win);
      default:                    return int'(req.addr) + k * step;
    endcase
  endfunction

  function automatic logic [31:0] expected_data(input axi_slave_pkg::addr_req_t req, input int k);
    logic [31:0] d;
    d = '0;
    if (expected_resp(req) != axi_slave_pkg::RESP_OKAY) return d;  // error beats carry zeros
    for (int j = 0; j < (1 << req.size); j++) begin
      d[8*j +: 8] = model_mem[idx_t'(model_addr(req, k) + j)];
    end
    return d;
  endfunction

  ////////////////////////////////////////////////////////////
  // checks and bookkeeping
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic abort_run(input string what);
    $display("timeout at %0t: %s", $time, what);
    $display("Done: errors found");
    $finish;
  endtask

  task automatic finish_test(input string name);
    if (errors == errors_at_start) $display("%s: passed", name);
    else $display("%s: %0d failed checks", name, errors - errors_at_start);
    tests_run++;
    errors_at_start = errors;
  endtask

  ////////////////////////////////////////////////////////////
  // channel drivers called on a falling edge
  ////////////////////////////////////////////////////////////

  task automatic send_aw(input axi_slave_pkg::addr_req_t req);
    int n;
    aw       = req;
    aw_valid = 1'b1;
    n        = 0;
    while (!aw_ready && n < max_wait) begin
      @(negedge clk);
      n++;
    end
    if (!aw_ready) abort_run("write address was never accepted");
    @(negedge clk);                                  // transfer done on the rising edge
    aw_valid = 1'b0;
  endtask

  task automatic send_ar(input axi_slave_pkg::addr_req_t req);
    int n;
    ar       = req;
    ar_valid = 1'b1;
    n        = 0;
    while (!ar_ready && n < max_wait) begin
      @(negedge clk);
      n++;
    end
    if (!ar_ready) abort_run("read address was never accepted");
    @(negedge clk);
    ar_valid = 1'b0;
  endtask

  task automatic write_burst(input axi_slave_pkg::addr_req_t req, input logic bp);
    axi_slave_pkg::w_beat_t beat;
    int n;
    send_aw(req);
    for (int k = 0; k <= int'(req.len); k++) begin
      beat.data = rand_bits(32);
      beat.strb = 4'(rand_bits(4));
      beat.last = (k == int'(req.len));
      w         = beat;
      w_valid   = 1'b1;
      n         = 0;
      while (!w_ready && n < max_wait) begin
        @(negedge clk);
        n++;
      end
      if (!w_ready) abort_run("write beat was never accepted");
      @(negedge clk);
      if (expected_resp(req) == axi_slave_pkg::RESP_OKAY) begin
        for (int j = 0; j < (1 << req.size); j++) begin
          if (beat.strb[j]) model_mem[idx_t'(model_addr(req, k) + j)] = beat.data[8*j +: 8];
        end
      end
    end
    w_valid = 1'b0;
    n       = 0;
    b_ready = bp ? next_bit() : 1'b1;
    while (!(b_valid && b_ready) && n < max_wait) begin
      @(negedge clk);
      b_ready = bp ? next_bit() : 1'b1;                // random back-pressure
      n++;
    end
    if (!(b_valid && b_ready)) abort_run("write response never arrived");
    check_value("b.id", 32'(b.id), 32'(req.id));
    check_value("b.resp", 32'(b.resp), 32'(expected_resp(req)));
    @(negedge clk);
    b_ready = 1'b0;
  endtask

  task automatic read_burst(input axi_slave_pkg::addr_req_t req, input logic bp);
    int n;
    send_ar(req);
    for (int k = 0; k <= int'(req.len); k++) begin
      n       = 0;
      r_ready = bp ? next_bit() : 1'b1;
      while (!(r_valid && r_ready) && n < max_wait) begin
        @(negedge clk);
        r_ready = bp ? next_bit() : 1'b1;
        n++;
      end
      if (!(r_valid && r_ready)) abort_run("read beat never arrived");
      check_value("r.data", r.data, expected_data(req, k));
      check_value("r.resp", 32'(r.resp), 32'(expected_resp(req)));
      check_value("r.last", 32'(r.last), 32'(k == int'(req.len)));
      check_value("r.id", 32'(r.id), 32'(req.id));
      @(negedge clk);
    end
    r_ready = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    resetn   = 1'b0;
    aw_valid = 1'b0;
    aw       = '0;
    w_valid  = 1'b0;
    w        = '0;
    b_ready  = 1'b0;
    ar_valid = 1'b0;
    ar       = '0;
    r_ready  = 1'b0;
    for (int i = 0; i < axi_slave_pkg::MEM_BYTES; i++) begin
      model_mem[i] = axi_slave_pkg::MEM_INIT;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;
    @(negedge clk);

    check_value("aw_ready", 32'(aw_ready), 32'd1);
    check_value("ar_ready", 32'(ar_ready), 32'd1);
    check_value("w_ready", 32'(w_ready), 32'd0);
    check_value("b_valid", 32'(b_valid), 32'd0);
    check_value("r_valid", 32'(r_valid), 32'd0);
    read_burst(make_req(4'd1, 32'h7E, 4'd0, 3'd2, axi_slave_pkg::BURST_INCR), 1'b0);  // lanes wrap
    finish_test("reset state");

    write_burst(make_req(4'd5, 32'h10, 4'd3, 3'd2, axi_slave_pkg::BURST_INCR), 1'b0);
    read_burst(make_req(4'd6, 32'h10, 4'd3, 3'd2, axi_slave_pkg::BURST_INCR), 1'b0);
    finish_test("incr burst with strobes");

    write_burst(make_req(4'd2, 32'h26, 4'd3, 3'd1, axi_slave_pkg::BURST_WRAP), 1'b0);
    read_burst(make_req(4'd3, 32'h26, 4'd3, 3'd1, axi_slave_pkg::BURST_WRAP), 1'b0);
    finish_test("wrap burst");

    write_burst(make_req(4'd7, 32'h40, 4'd2, 3'd2, axi_slave_pkg::BURST_FIXED), 1'b0);
    read_burst(make_req(4'd8, 32'h40, 4'd2, 3'd2, axi_slave_pkg::BURST_FIXED), 1'b0);
    finish_test("fixed burst");

    // address 200 lands on byte 0x48 once folded into the memory
    write_burst(make_req(4'd9, 32'd200, 4'd1, 3'd2, axi_slave_pkg::BURST_INCR), 1'b0);
    write_burst(make_req(4'd10, 32'h50, 4'd1, 3'd3, axi_slave_pkg::BURST_INCR), 1'b0);
    write_burst(make_req(4'd11, 32'h50, 4'd2, 3'd2, axi_slave_pkg::BURST_WRAP), 1'b0);
    read_burst(make_req(4'd12, 32'h48, 4'd5, 3'd2, axi_slave_pkg::BURST_INCR), 1'b0);
    read_burst(make_req(4'd13, 32'd200, 4'd2, 3'd2, axi_slave_pkg::BURST_INCR), 1'b0);
    read_burst(make_req(4'd14, 32'h08, 4'd1, 3'd3, axi_slave_pkg::BURST_INCR), 1'b0);
    finish_test("error responses");

    write_burst(make_req(4'd4, 32'h60, 4'd15, 3'd2, axi_slave_pkg::BURST_INCR), 1'b1);
    read_burst(make_req(4'd15, 32'h60, 4'd15, 3'd2, axi_slave_pkg::BURST_INCR), 1'b1);
    finish_test("back-pressure");

    $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- src/axi_slave_top.sv
// slave top: write and read controllers sharing one byte memory
`timescale 1ns/10ps

module axi_slave_top (
  input  logic                         clk,
  input  logic                         resetn,
  input  logic                         aw_valid,
  output logic                         aw_ready,
  input  axi_slave_pkg::addr_req_t     aw,
  input  logic                         w_valid,
  output logic                         w_ready,
  input  axi_slave_pkg::w_beat_t       w,
  output logic                         b_valid,
  input  logic                         b_ready,
  output axi_slave_pkg::b_resp_t       b,
  input  logic                         ar_valid,
  output logic                         ar_ready,
  input  axi_slave_pkg::addr_req_t     ar,
  output logic                         r_valid,
  input  logic                         r_ready,
  output axi_slave_pkg::r_beat_t       r
);

  logic                                  mem_wr_en;
  logic [axi_slave_pkg::ADDR_W-1:0]      mem_wr_addr;
  logic [axi_slave_pkg::DATA_W-1:0]      mem_wr_data;
  logic [axi_slave_pkg::DATA_BYTES-1:0]  mem_wr_be;
  logic [axi_slave_pkg::ADDR_W-1:0]      mem_rd_addr;
  logic [axi_slave_pkg::DATA_W-1:0]      mem_rd_data;

  axi_write_ctrl u_write_ctrl (
    .clk, .resetn,
    .aw_valid, .aw_ready, .aw,
    .w_valid, .w_ready, .w,
    .b_valid, .b_ready, .b,
    .mem_wr_en, .mem_wr_addr, .mem_wr_data, .mem_wr_be
  );

  axi_read_ctrl u_read_ctrl (
    .clk, .resetn,
    .ar_valid, .ar_ready, .ar,
    .r_valid, .r_ready, .r,
    .mem_rd_addr, .mem_rd_data
  );

  byte_mem u_mem (
    .clk, .resetn,
    .wr_en   (mem_wr_en),
    .wr_addr (mem_wr_addr),
    .wr_data (mem_wr_data),
    .wr_be   (mem_wr_be),
    .rd_addr (mem_rd_addr),
    .rd_data (mem_rd_data)
  );

endmodule

//--- read_ch/axi_read_ctrl.sv
// read channel FSM: ar accept, registered r beats from memory
`timescale 1ns/10ps

module axi_read_ctrl (
  input  logic                              clk,
  input  logic                              resetn,
  input  logic                              ar_valid,
  output logic                              ar_ready,
  input  axi_slave_pkg::addr_req_t          ar,
  output logic                              r_valid,
  input  logic                              r_ready,
  output axi_slave_pkg::r_beat_t            r,
  output logic [axi_slave_pkg::ADDR_W-1:0]  mem_rd_addr,
  input  logic [axi_slave_pkg::DATA_W-1:0]  mem_rd_data
);

  typedef enum logic {R_ADDR, R_DATA} r_state_e;

  r_state_e                          state;
  axi_slave_pkg::addr_req_t          req_q;
  axi_slave_pkg::addr_req_t          req_sel;    // request of the beat being fetched
  logic [axi_slave_pkg::ADDR_W-1:0]  cur_addr;
  logic [axi_slave_pkg::ADDR_W-1:0]  next_addr;
  logic [axi_slave_pkg::LEN_W-1:0]   beat_cnt;
  logic [axi_slave_pkg::LEN_W-1:0]   beat_idx;   // index of the fetched beat
  logic [axi_slave_pkg::DATA_W-1:0]  data_mask;
  axi_slave_pkg::resp_e              resp;
  axi_slave_pkg::r_beat_t            beat_next;
  logic                              ar_fire;
  logic                              r_fire;

  burst_addr_gen u_addr_gen (
    .req       (req_sel),
    .beat_addr (cur_addr),
    .next_addr (next_addr),
    .resp      (resp)
  );

  assign ar_ready    = (state == R_ADDR);
  assign r_valid     = (state == R_DATA);
  assign ar_fire     = ar_valid && ar_ready;
  assign r_fire      = r_valid && r_ready;
  assign req_sel     = (state == R_ADDR) ? ar : req_q;
  assign mem_rd_addr = (state == R_ADDR) ? ar.addr : next_addr;  // fetch one beat ahead
  assign beat_idx    = (state == R_ADDR) ? '0 : beat_cnt + 1'b1;

  always_comb begin
    for (int j = 0; j < axi_slave_pkg::DATA_BYTES; j++) begin
      data_mask[8*j +: 8] = {8{j < (1 << req_sel.size)}};
    end
  end

  always_comb begin
    beat_next.id   = req_sel.id;
    beat_next.resp = resp;
    beat_next.last = (beat_idx == req_sel.len);
    beat_next.data = (resp == axi_slave_pkg::RESP_OKAY) ? (mem_rd_data & data_mask) : '0;
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state    <= R_ADDR;
      beat_cnt <= '0;
    end else if (ar_fire) begin
      state    <= R_DATA;
      beat_cnt <= '0;
    end else if (r_fire) begin
      if (r.last) state <= R_ADDR;
      else beat_cnt <= beat_cnt + 1'b1;
    end
  end

  // r is held in a register so back-pressure keeps it frozen
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      req_q    <= ar;
      cur_addr <= ar.addr;
      r        <= beat_next;
    end else if (r_fire && !r.last) begin
      cur_addr <= next_addr;
      r        <= beat_next;
    end
  end

  a_r_stable: assert property (@(posedge clk) disable iff (!resetn)
    r_valid && !r_ready |=> r_valid && $stable(r))
    else $error("r changed while waiting for r_ready");

endmodule

//--- write_ch/axi_write_ctrl.sv
// write channel FSM: aw accept, w beats into memory, b response
`timescale 1ns/10ps

module axi_write_ctrl (
  input  logic                                  clk,
  input  logic                                  resetn,
  input  logic                                  aw_valid,
  output logic                                  aw_ready,
  input  axi_slave_pkg::addr_req_t              aw,
  input  logic                                  w_valid,
  output logic                                  w_ready,
  input  axi_slave_pkg::w_beat_t                w,
  output logic                                  b_valid,
  input  logic                                  b_ready,
  output axi_slave_pkg::b_resp_t                b,
  output logic                                  mem_wr_en,
  output logic [axi_slave_pkg::ADDR_W-1:0]      mem_wr_addr,
  output logic [axi_slave_pkg::DATA_W-1:0]      mem_wr_data,
  output logic [axi_slave_pkg::DATA_BYTES-1:0]  mem_wr_be
);

  typedef enum logic [1:0] {W_ADDR, W_DATA, W_RESP} w_state_e;

  w_state_e                          state;
  axi_slave_pkg::addr_req_t          req_q;      // accepted request
  logic [axi_slave_pkg::ADDR_W-1:0]  cur_addr;
  logic [axi_slave_pkg::ADDR_W-1:0]  next_addr;
  logic [axi_slave_pkg::LEN_W-1:0]   beat_cnt;   // beats done so far
  axi_slave_pkg::resp_e              resp;
  logic [axi_slave_pkg::DATA_BYTES-1:0] lane_mask;
  logic                              aw_fire;
  logic                              w_fire;
  logic                              last_beat;

  burst_addr_gen u_addr_gen (
    .req       (req_q),
    .beat_addr (cur_addr),
    .next_addr (next_addr),
    .resp      (resp)
  );

  assign aw_ready  = (state == W_ADDR);
  assign w_ready   = (state == W_DATA);
  assign b_valid   = (state == W_RESP);
  assign aw_fire   = aw_valid && aw_ready;
  assign w_fire    = w_valid && w_ready;
  assign last_beat = (beat_cnt == req_q.len);
  assign b         = '{id: req_q.id, resp: resp};

  // first 2^size lanes of the beat
  always_comb begin
    for (int j = 0; j < axi_slave_pkg::DATA_BYTES; j++) begin
      lane_mask[j] = (j < (1 << req_q.size));
    end
  end

  assign mem_wr_en   = w_fire && (resp == axi_slave_pkg::RESP_OKAY);  // errors write nothing
  assign mem_wr_addr = cur_addr;
  assign mem_wr_data = w.data;
  assign mem_wr_be   = w.strb & lane_mask;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state    <= W_ADDR;
      beat_cnt <= '0;
    end else begin
      case (state)
        W_ADDR: if (aw_fire) begin
          state    <= W_DATA;
          beat_cnt <= '0;
        end
        W_DATA: if (w_fire) begin
          beat_cnt <= beat_cnt + 1'b1;
          if (last_beat) state <= W_RESP;   // burst length from the count
        end
        default: if (b_ready) state <= W_ADDR;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      req_q    <= aw;
      cur_addr <= aw.addr;
    end else if (w_fire) begin
      cur_addr <= next_addr;
    end
  end

  a_wlast: assert property (@(posedge clk) disable iff (!resetn)
    w_fire |-> (w.last == last_beat))
    else $error("wlast does not match the beat count");

  a_b_stable: assert property (@(posedge clk) disable iff (!resetn)
    b_valid && !b_ready |=> b_valid && $stable(b))
    else $error("b changed while waiting for b_ready");

endmodule

//--- src/byte_mem.sv
// byte addressed memory, strobed 4-lane write port and 4-lane async read port
`timescale 1ns/10ps

module byte_mem (
  input  logic                                     clk,
  input  logic                                     resetn,
  input  logic                                     wr_en,
  input  logic [axi_slave_pkg::ADDR_W-1:0]         wr_addr,
  input  logic [axi_slave_pkg::DATA_W-1:0]         wr_data,
  input  logic [axi_slave_pkg::DATA_BYTES-1:0]     wr_be,
  input  logic [axi_slave_pkg::ADDR_W-1:0]         rd_addr,
  output logic [axi_slave_pkg::DATA_W-1:0]         rd_data
);

  typedef logic [axi_slave_pkg::MEM_AW-1:0] idx_t;

  logic [7:0] mem [axi_slave_pkg::MEM_BYTES];
  idx_t       wr_idx [axi_slave_pkg::DATA_BYTES];  // per lane byte index
  idx_t       rd_idx [axi_slave_pkg::DATA_BYTES];

  // lane j sits at base + j, wrapping modulo the memory size
  for (genvar j = 0; j < axi_slave_pkg::DATA_BYTES; j++) begin : g_lane
    assign wr_idx[j] = wr_addr[axi_slave_pkg::MEM_AW-1:0] + idx_t'(j);
    assign rd_idx[j] = rd_addr[axi_slave_pkg::MEM_AW-1:0] + idx_t'(j);
    assign rd_data[8*j +: 8] = mem[rd_idx[j]];
  end

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      for (int i = 0; i < axi_slave_pkg::MEM_BYTES; i++) begin
        mem[i] <= axi_slave_pkg::MEM_INIT;
      end
    end else if (wr_en) begin
      for (int j = 0; j < axi_slave_pkg::DATA_BYTES; j++) begin
        if (wr_be[j]) begin
          mem[wr_idx[j]] <= wr_data[8*j +: 8];  // only enabled lanes
        end
      end
    end
  end

endmodule

//--- src/burst_addr_gen.sv
// next beat address for FIXED/INCR/WRAP bursts and request response decode
`timescale 1ns/10ps

module burst_addr_gen (
  input  axi_slave_pkg::addr_req_t              req,
  input  logic [axi_slave_pkg::ADDR_W-1:0]      beat_addr,
  output logic [axi_slave_pkg::ADDR_W-1:0]      next_addr,
  output axi_slave_pkg::resp_e                  resp
);

  logic [axi_slave_pkg::ADDR_W-1:0] step;       // bytes per beat
  logic [axi_slave_pkg::ADDR_W-1:0] wrap_mask;  // window size - 1
  logic [axi_slave_pkg::ADDR_W-1:0] incr_addr;

  assign step = {{(axi_slave_pkg::ADDR_W-1){1'b0}}, 1'b1} << req.size;
  assign wrap_mask = (({{(axi_slave_pkg::ADDR_W-axi_slave_pkg::LEN_W){1'b0}}, req.len} + 1)
                      << req.size) - 1;
  assign incr_addr = beat_addr + step;

  always_comb begin
    case (req.burst)
      axi_slave_pkg::BURST_FIXED: next_addr = beat_addr;
      // stay inside the aligned window, fold back at its top
      axi_slave_pkg::BURST_WRAP:  next_addr = (beat_addr & ~wrap_mask) | (incr_addr & wrap_mask);
      default:                    next_addr = incr_addr;
    endcase
  end

  // address decode wins over size and wrap length checks
  always_comb begin
    if (req.addr >= axi_slave_pkg::MEM_BYTES) begin
      resp = axi_slave_pkg::RESP_DECERR;
    end else if (req.size > axi_slave_pkg::MAX_SIZE) begin
      resp = axi_slave_pkg::RESP_SLVERR;
    end else if (req.burst == axi_slave_pkg::BURST_WRAP &&
                 !(req.len inside {4'd1, 4'd3, 4'd7, 4'd15})) begin
      resp = axi_slave_pkg::RESP_SLVERR;              // wrap needs 2/4/8/16 beats
    end else begin
      resp = axi_slave_pkg::RESP_OKAY;
    end
  end

endmodule

//--- common/axi_slave_pkg.sv
// shared localparams, burst and response enums, channel payload structs

package axi_slave_pkg;

  ////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////

  localparam int DATA_BYTES = 4;                // bytes per data beat
  localparam int DATA_W     = 8 * DATA_BYTES;   // data bus width
  localparam int ADDR_W     = 32;
  localparam int ID_W       = 4;
  localparam int LEN_W      = 4;                // beats = len + 1
  localparam int SIZE_W     = 3;
  localparam int MEM_BYTES  = 128;
  localparam int MEM_AW     = $clog2(MEM_BYTES); // byte index width
  localparam logic [7:0] MEM_INIT = 8'h0C;      // every byte after reset
  localparam int MAX_SIZE   = 2;                // 4-byte beats at most

  ////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  ////////////////////////////////////////////////////////////
  // channel payloads
  ////////////////////////////////////////////////////////////

  // aw and ar request, 45 bits
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
    logic [SIZE_W-1:0] size;   // log2 of beat bytes
    burst_e            burst;
  } addr_req_t;

  // write data beat, 37 bits
  typedef struct packed {
    logic [DATA_W-1:0]     data;
    logic [DATA_BYTES-1:0] strb;  // lane j carries byte j
    logic                  last;
  } w_beat_t;

  // write response, 6 bits
  typedef struct packed {
    logic [ID_W-1:0] id;
    resp_e           resp;
  } b_resp_t;

  // read data beat, 39 bits
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    resp_e             resp;
    logic              last;
  } r_beat_t;

endpackage
